// ==== design/execute_ctl_pkg.sv ====
package execute_ctl_pkg;

    // One instruction word
    localparam int XLEN = 32;

    // Major opcodes, instruction[6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // funct3 for OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_arith_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } funct3_branch_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } funct3_load_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } funct3_store_e;

    // funct7, alternate form selects SUB and SRA
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } funct7_e;

    typedef enum logic [3:0] {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_XOR    = 4'd2,
        ALU_ADD    = 4'd3,
        ALU_SUB    = 4'd4,
        ALU_PASS_B = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd10,
        ALU_SLTU   = 4'd11,
        ALU_SLT    = 4'd12
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_R = 3'd0,
        IMM_I = 3'd1,
        IMM_S = 3'd2,
        IMM_B = 3'd3,
        IMM_U = 3'd4,
        IMM_J = 3'd5
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_MEM      = 2'd0,
        WB_ALU      = 2'd1,
        WB_PC_PLUS4 = 2'd2
    } wb_sel_e;

    // Signedness of LT/GE lives in br_un
    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,
        BR_GE     = 3'd4,
        BR_ALWAYS = 3'd5
    } br_cond_e;

    // Execute-stage control bundle
    typedef struct packed {
        logic     a_sel;
        logic     b_sel;
        alu_op_e  alu_op;
        imm_sel_e imm_sel;
        logic     mem_wr;
        logic     reg_wen;
        logic     br_un;
        wb_sel_e  wb_sel;
        logic     load_sign;
    } ctl_t;

    // All zero, nothing written and nothing stored
    localparam ctl_t CTL_NOP = '0;

endpackage

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic [execute_ctl_pkg::XLEN-1:0] instruction,
    output execute_ctl_pkg::ctl_t            ctl,
    output execute_ctl_pkg::br_cond_e        br_cond
);

    import execute_ctl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       f7_base;
    logic       f7_alt;

    alu_op_e    arith_op;
    logic       arith_ok;
    logic       load_ok;
    logic       load_sign;
    logic       store_ok;
    br_cond_e   branch_cond;
    logic       branch_un;

    assign opcode  = opcode_e'(instruction[6:0]);
    assign funct3  = instruction[14:12];
    assign funct7  = instruction[31:25];
    assign is_op   = (opcode == OPC_OP);
    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    // ALU operation shared by OP and OP-IMM
    // For OP-IMM, funct7 is immediate bits except on shifts
    always_comb begin
        arith_op = ALU_ADD;
        arith_ok = 1'b0;
        case (funct3)
            F3_ADD_SUB: begin
                arith_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
                arith_ok = !is_op || f7_base || f7_alt;
            end
            F3_SLL: begin
                arith_op = ALU_SLL;
                arith_ok = f7_base;
            end
            F3_SLT: begin
                arith_op = ALU_SLT;
                arith_ok = !is_op || f7_base;
            end
            F3_SLTU: begin
                arith_op = ALU_SLTU;
                arith_ok = !is_op || f7_base;
            end
            F3_XOR: begin
                arith_op = ALU_XOR;
                arith_ok = !is_op || f7_base;
            end
            F3_SRL_SRA: begin
                // funct7 tells logical from arithmetic shift
                arith_op = f7_alt ? ALU_SRA : ALU_SRL;
                arith_ok = f7_base || f7_alt;
            end
            F3_OR: begin
                arith_op = ALU_OR;
                arith_ok = !is_op || f7_base;
            end
            F3_AND: begin
                arith_op = ALU_AND;
                arith_ok = !is_op || f7_base;
            end
            default: begin
                arith_op = ALU_ADD;
                arith_ok = 1'b0;
            end
        endcase
    end

    // Sign extension only for LB, LH and LW
    always_comb begin
        load_ok   = 1'b1;
        load_sign = 1'b0;
        case (funct3)
            F3_LB, F3_LH, F3_LW: begin
                load_sign = 1'b1;
            end
            F3_LBU, F3_LHU: begin
                load_sign = 1'b0;
            end
            default: begin
                load_ok = 1'b0;
            end
        endcase
    end

    assign store_ok = funct3 inside {F3_SB, F3_SH, F3_SW};

    always_comb begin
        branch_cond = BR_NONE;
        branch_un   = 1'b0;
        case (funct3)
            F3_BEQ: begin
                branch_cond = BR_EQ;
            end
            F3_BNE: begin
                branch_cond = BR_NE;
            end
            F3_BLT: begin
                branch_cond = BR_LT;
            end
            F3_BGE: begin
                branch_cond = BR_GE;
            end
            F3_BLTU: begin
                branch_cond = BR_LT;
                branch_un   = 1'b1;
            end
            F3_BGEU: begin
                branch_cond = BR_GE;
                branch_un   = 1'b1;
            end
            default: begin
                branch_cond = BR_NONE;
            end
        endcase
    end

    always_comb begin
        ctl     = CTL_NOP;
        br_cond = BR_NONE;
        case (opcode)
            OPC_LUI: begin
                ctl.b_sel   = 1'b1;
                ctl.alu_op  = ALU_PASS_B;
                ctl.imm_sel = IMM_U;
                ctl.reg_wen = 1'b1;
                ctl.wb_sel  = WB_ALU;
            end
            OPC_AUIPC: begin
                ctl.a_sel   = 1'b1;
                ctl.b_sel   = 1'b1;
                ctl.alu_op  = ALU_ADD;
                ctl.imm_sel = IMM_U;
                ctl.reg_wen = 1'b1;
                ctl.wb_sel  = WB_ALU;
            end
            OPC_JAL: begin
                ctl.a_sel   = 1'b1;
                ctl.b_sel   = 1'b1;
                ctl.alu_op  = ALU_ADD;
                ctl.imm_sel = IMM_J;
                ctl.reg_wen = 1'b1;
                ctl.wb_sel  = WB_PC_PLUS4;
                br_cond     = BR_ALWAYS;
            end
            OPC_JALR: begin
                // Target is rs1 + imm, funct3 must be zero
                if (funct3 == 3'b000) begin
                    ctl.b_sel   = 1'b1;
                    ctl.alu_op  = ALU_ADD;
                    ctl.imm_sel = IMM_I;
                    ctl.reg_wen = 1'b1;
                    ctl.wb_sel  = WB_PC_PLUS4;
                    br_cond     = BR_ALWAYS;
                end
            end
            OPC_BRANCH: begin
                // ALU forms the target PC + imm
                if (branch_cond != BR_NONE) begin
                    ctl.a_sel   = 1'b1;
                    ctl.b_sel   = 1'b1;
                    ctl.alu_op  = ALU_ADD;
                    ctl.imm_sel = IMM_B;
                    ctl.br_un   = branch_un;
                    br_cond     = branch_cond;
                end
            end
            OPC_LOAD: begin
                if (load_ok) begin
                    ctl.b_sel     = 1'b1;
                    ctl.alu_op    = ALU_ADD;
                    ctl.imm_sel   = IMM_I;
                    ctl.reg_wen   = 1'b1;
                    ctl.wb_sel    = WB_MEM;
                    ctl.load_sign = load_sign;
                end
            end
            OPC_STORE: begin
                if (store_ok) begin
                    ctl.b_sel   = 1'b1;
                    ctl.alu_op  = ALU_ADD;
                    ctl.imm_sel = IMM_S;
                    ctl.mem_wr  = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (arith_ok) begin
                    ctl.b_sel   = 1'b1;
                    ctl.alu_op  = arith_op;
                    ctl.imm_sel = IMM_I;
                    ctl.reg_wen = 1'b1;
                    ctl.wb_sel  = WB_ALU;
                end
            end
            OPC_OP: begin
                if (arith_ok) begin
                    ctl.alu_op  = arith_op;
                    ctl.imm_sel = IMM_R;
                    ctl.reg_wen = 1'b1;
                    ctl.wb_sel  = WB_ALU;
                end
            end
            OPC_MISC_MEM, OPC_SYSTEM: begin
                // FENCE, ECALL and EBREAK retire as no-ops
                ctl     = CTL_NOP;
                br_cond = BR_NONE;
            end
            default: begin
                ctl     = CTL_NOP;
                br_cond = BR_NONE;
            end
        endcase
    end

endmodule

// ==== design/branch_resolve_stage.sv ====
`timescale 1ns/1ps

module branch_resolve_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  execute_ctl_pkg::ctl_t     ctl,
    input  execute_ctl_pkg::br_cond_e br_cond,
    input  logic                      br_eq,
    input  logic                      br_lt,
    output execute_ctl_pkg::ctl_t     ctl_q,
    output logic                      pc_sel
);

    import execute_ctl_pkg::*;

    logic take_branch;

    // Comparator flags are for the instruction decoded this cycle
    // br_lt already reflects br_un from the comparator
    always_comb begin
        case (br_cond)
            BR_ALWAYS: begin
                take_branch = 1'b1;
            end
            BR_EQ: begin
                take_branch = br_eq;
            end
            BR_NE: begin
                take_branch = !br_eq;
            end
            BR_LT: begin
                take_branch = br_lt;
            end
            BR_GE: begin
                take_branch = !br_lt;
            end
            default: begin
                take_branch = 1'b0;
            end
        endcase
    end

    // Single pipeline register for bundle and redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_q  <= CTL_NOP;
            pc_sel <= 1'b0;
        end else begin
            ctl_q  <= ctl;
            pc_sel <= take_branch;
        end
    end

endmodule

// ==== design/execute_ctl.sv ====
`timescale 1ns/1ps

module execute_ctl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [execute_ctl_pkg::XLEN-1:0] instruction,
    input  logic                             br_eq,
    input  logic                             br_lt,
    output execute_ctl_pkg::ctl_t            ctl,
    output logic                             pc_sel
);

    import execute_ctl_pkg::*;

    // Decoder outputs, same cycle as the instruction
    ctl_t     dec_ctl;
    br_cond_e dec_br_cond;

    instr_decoder u_decoder (
        .instruction (instruction),
        .ctl         (dec_ctl),
        .br_cond     (dec_br_cond)
    );

    // One cycle to the outputs
    branch_resolve_stage u_resolve (
        .clk     (clk),
        .reset   (reset),
        .ctl     (dec_ctl),
        .br_cond (dec_br_cond),
        .br_eq   (br_eq),
        .br_lt   (br_lt),
        .ctl_q   (ctl),
        .pc_sel  (pc_sel)
    );

endmodule

// ==== tb/ctl_model.svh ====
`ifndef CTL_MODEL_SVH
`define CTL_MODEL_SVH

localparam opcode_e LISTED_OPCODES [11] = '{
    OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
    OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM
};

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
endtask

function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [6:0] opc);
    return {f7, 5'd6, 5'd5, f3, 5'd4, opc};
endfunction

// Listed opcode most of the time, now and then a raw word
task automatic random_instr(output logic [31:0] instr);
    logic [31:0] pick;
    logic [31:0] f3;
    logic [31:0] f7;
    logic [31:0] regs;
    logic [6:0]  opc;
    take_bits(4, pick);
    if (pick[3:0] >= 4'd14) begin
        take_bits(32, instr);
    end else begin
        if (pick[3:0] < 4'd11) begin
            opc = LISTED_OPCODES[pick[3:0]];
        end else begin
            opc = pick[0] ? OPC_OP : OPC_OP_IMM;
        end
        take_bits(3, f3);
        take_bits(2, f7);
        if (f7[1]) begin
            take_bits(7, f7);
        end else begin
            f7 = f7[0] ? 32'h20 : 32'h00;
        end
        take_bits(15, regs);
        instr = {f7[6:0], regs[14:5], f3[2:0], regs[4:0], opc};
    end
endtask

// Every listed opcode ends in 2'b11
task automatic random_unlisted(output logic [6:0] opc);
    logic [31:0] bits;
    take_bits(7, bits);
    opc = bits[6:0];
    if (opc[1:0] == 2'b11) begin
        opc[1:0] = 2'b00;
    end
endtask

function automatic ctl_t pack_ctl(input logic a, input logic b, input alu_op_e op,
                                  input imm_sel_e imm, input logic mw, input logic rw,
                                  input logic un, input wb_sel_e wb, input logic ls);
    return '{a, b, op, imm, mw, rw, un, wb, ls};
endfunction

function automatic alu_op_e alu_for(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
        3'd0: op = alt ? ALU_SUB : ALU_ADD;
        3'd1: op = ALU_SLL;
        3'd2: op = ALU_SLT;
        3'd3: op = ALU_SLTU;
        3'd4: op = ALU_XOR;
        3'd5: op = alt ? ALU_SRA : ALU_SRL;
        3'd6: op = ALU_OR;
        default: op = ALU_AND;
    endcase
    return op;
endfunction

// Expected bundle and redirect for one instruction and its flags
function automatic ctl_t model_ctl(input logic [31:0] instr, input logic eq, input logic lt,
                                   output logic exp_pc);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    logic       imm_ok;
    ctl_t       c;
    br_cond_e   cond;
    opc = instr[6:0];
    f3 = instr[14:12];
    f7 = instr[31:25];
    alt = (f7 == 7'h20);
    c = CTL_NOP;
    cond = BR_NONE;
    imm_ok = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 == 3'd5) ? (f7 == 7'h00 || alt) : 1'b1;
    case (opc)
        OPC_LUI: c = pack_ctl(1'b0, 1'b1, ALU_PASS_B, IMM_U, 1'b0, 1'b1, 1'b0, WB_ALU, 1'b0);
        OPC_AUIPC: c = pack_ctl(1'b1, 1'b1, ALU_ADD, IMM_U, 1'b0, 1'b1, 1'b0, WB_ALU, 1'b0);
        OPC_JAL: begin
            c = pack_ctl(1'b1, 1'b1, ALU_ADD, IMM_J, 1'b0, 1'b1, 1'b0, WB_PC_PLUS4, 1'b0);
            cond = BR_ALWAYS;
        end
        OPC_JALR: begin
            if (f3 == 3'd0) begin
                c = pack_ctl(1'b0, 1'b1, ALU_ADD, IMM_I, 1'b0, 1'b1, 1'b0, WB_PC_PLUS4, 1'b0);
                cond = BR_ALWAYS;
            end
        end
        OPC_BRANCH: begin
            if (f3[2:1] != 2'b01) begin
                c = pack_ctl(1'b1, 1'b1, ALU_ADD, IMM_B, 1'b0, 1'b0, f3[1], WB_MEM, 1'b0);
                cond = f3[2] ? (f3[0] ? BR_GE : BR_LT) : (f3[0] ? BR_NE : BR_EQ);
            end
        end
        OPC_LOAD: begin
            if (f3 != 3'd3 && f3 < 3'd6) begin
                c = pack_ctl(1'b0, 1'b1, ALU_ADD, IMM_I, 1'b0, 1'b1, 1'b0, WB_MEM, !f3[2]);
            end
        end
        OPC_STORE: begin
            if (f3 < 3'd3) begin
                c = pack_ctl(1'b0, 1'b1, ALU_ADD, IMM_S, 1'b1, 1'b0, 1'b0, WB_MEM, 1'b0);
            end
        end
        OPC_OP_IMM: begin
            if (imm_ok) begin
                c = pack_ctl(1'b0, 1'b1, alu_for(f3, alt && f3 == 3'd5), IMM_I, 1'b0, 1'b1,
                             1'b0, WB_ALU, 1'b0);
            end
        end
        OPC_OP: begin
            if (f7 == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5))) begin
                c = pack_ctl(1'b0, 1'b0, alu_for(f3, alt), IMM_R, 1'b0, 1'b1, 1'b0, WB_ALU, 1'b0);
            end
        end
        default: c = CTL_NOP;
    endcase
    case (cond)
        BR_ALWAYS: exp_pc = 1'b1;
        BR_EQ: exp_pc = eq;
        BR_NE: exp_pc = !eq;
        BR_LT: exp_pc = lt;
        BR_GE: exp_pc = !lt;
        default: exp_pc = 1'b0;
    endcase
    return c;
endfunction

task automatic compare_ctl(input string name, input ctl_t expected, input ctl_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        test_errors++;
        $display("Mismatch %s: ctl expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic compare_pc_sel(input string name, input bit expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        test_errors++;
        $display("Mismatch %s: pc_sel expected %b, actual %b", name, expected, actual);
    end
endtask

`endif

// ==== tb/tb_execute_ctl.sv ====
`timescale 1ns/1ps

module tb_execute_ctl;

    import execute_ctl_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int RESET_VECS    = RESET_CYCLES + 1;
    localparam int TABLE_VECS    = 37;
    localparam int BRANCH_VECS   = 48;
    localparam int UNKNOWN_VECS  = 26;
    localparam int RANDOM_VECS   = 400;
    localparam int MIDRESET_VECS = 40;
    localparam int NUM_TESTS     = 6;
    localparam int CYCLE_LIMIT   = RESET_VECS + TABLE_VECS + BRANCH_VECS + UNKNOWN_VECS
                                 + RANDOM_VECS + MIDRESET_VECS + NUM_TESTS + 50;

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] instruction;
    logic            br_eq;
    logic            br_lt;
    ctl_t            ctl;
    logic            pc_sel;

    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;
    int          test_errors;
    int          cycle_count;
    string       test_name;

    // Expectation for the vector driven one cycle earlier
    logic        pend_valid;
    ctl_t        pend_ctl;
    logic        pend_pc;
    logic [31:0] pend_instr;

    `include "ctl_model.svh"

    execute_ctl DUT (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .ctl         (ctl),
        .pc_sel      (pc_sel)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_pending();
        if (pend_valid) begin
            compare_ctl($sformatf("%s instr %h", test_name, pend_instr), pend_ctl, ctl);
            compare_pc_sel($sformatf("%s instr %h", test_name, pend_instr), pend_pc, pc_sel);
        end
    endtask

    // One vector per cycle, checked at the following falling edge
    task automatic step(input logic [31:0] instr, input logic eq, input logic lt,
                        input logic rst);
        logic exp_pc;
        @(negedge clk);
        check_pending();
        instruction = instr;
        br_eq = eq;
        br_lt = lt;
        reset = rst;
        pend_ctl = model_ctl(instr, eq, lt, exp_pc);
        pend_pc = exp_pc;
        if (rst) begin
            pend_ctl = CTL_NOP;
            pend_pc = 1'b0;
        end
        pend_instr = instr;
        pend_valid = 1'b1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        @(negedge clk);
        check_pending();
        pend_valid = 1'b0;
        instruction = '0;
        br_eq = 1'b0;
        br_lt = 1'b0;
        $display("%-16s %s (%0d errors)", test_name, test_errors == 0 ? "ok" : "FAILED",
                 test_errors);
    endtask

    // A negative reset_at keeps reset low for the whole stream
    task automatic run_random(input int count, input int reset_at);
        logic [31:0] instr;
        logic [31:0] flags;
        logic        rst;
        for (int i = 0; i < count; i++) begin
            random_instr(instr);
            take_bits(2, flags);
            rst = (reset_at >= 0) && (i == reset_at || i == reset_at + 1);
            step(instr, flags[1], flags[0], rst);
        end
    endtask

    initial begin
        logic [6:0]  opc;
        logic [31:0] flags;
        reset = 1'b1;
        instruction = '0;
        br_eq = 1'b0;
        br_lt = 1'b0;
        lfsr_state = 32'h3d0a;
        check_count = 0;
        error_count = 0;
        pend_valid = 1'b0;

        // JAL on the input would show up if reset were ignored
        start_test("reset_values");
        repeat (RESET_CYCLES) step(encode(7'h00, 3'd0, OPC_JAL), 1'b1, 1'b1, 1'b1);
        step(encode(7'h12, 3'd3, OPC_LUI), 1'b0, 1'b0, 1'b0);
        finish_test();

        start_test("instr_table");
        step(encode(7'h12, 3'd3, OPC_LUI), 1'b0, 1'b0, 1'b0);
        step(encode(7'h34, 3'd1, OPC_AUIPC), 1'b0, 1'b0, 1'b0);
        step(encode(7'h01, 3'd7, OPC_JAL), 1'b0, 1'b0, 1'b0);
        step(encode(7'h7f, 3'd0, OPC_JALR), 1'b0, 1'b0, 1'b0);
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                step(encode(7'h00, f3[2:0], OPC_BRANCH), 1'b0, 1'b0, 1'b0);
            end
            if (f3 != 3 && f3 < 6) begin
                step(encode(7'h3c, f3[2:0], OPC_LOAD), 1'b0, 1'b0, 1'b0);
            end
            if (f3 < 3) begin
                step(encode(7'h41, f3[2:0], OPC_STORE), 1'b0, 1'b0, 1'b0);
            end
            // Immediate bits in funct7 except on shifts
            step(encode((f3 == 1 || f3 == 5) ? 7'h00 : 7'h55, f3[2:0], OPC_OP_IMM),
                 1'b0, 1'b0, 1'b0);
            step(encode(7'h00, f3[2:0], OPC_OP), 1'b0, 1'b0, 1'b0);
        end
        step(encode(7'h20, 3'd5, OPC_OP_IMM), 1'b0, 1'b0, 1'b0);
        step(encode(7'h20, 3'd0, OPC_OP), 1'b0, 1'b0, 1'b0);
        step(encode(7'h20, 3'd5, OPC_OP), 1'b0, 1'b0, 1'b0);
        finish_test();

        start_test("branch_resolve");
        for (int f = 0; f < 4; f++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                if (f3 != 2 && f3 != 3) begin
                    step(encode(7'h00, f3[2:0], OPC_BRANCH), f[1], f[0], 1'b0);
                end
            end
            step(encode(7'h00, 3'd0, OPC_JAL), f[1], f[0], 1'b0);
            step(encode(7'h00, 3'd0, OPC_JALR), f[1], f[0], 1'b0);
            step(encode(7'h00, 3'd0, OPC_OP), f[1], f[0], 1'b0);
            step(encode(7'h00, 3'd2, OPC_LOAD), f[1], f[0], 1'b0);
            step(encode(7'h00, 3'd2, OPC_STORE), f[1], f[0], 1'b0);
            step(encode(7'h00, 3'd0, OPC_LUI), f[1], f[0], 1'b0);
        end
        finish_test();

        start_test("unknown_nop");
        step(32'h0ff0000f, 1'b1, 1'b0, 1'b0);
        step(32'h00000073, 1'b1, 1'b0, 1'b0);
        step(32'h00100073, 1'b1, 1'b0, 1'b0);
        step(encode(7'h00, 3'd2, OPC_BRANCH), 1'b1, 1'b0, 1'b0);
        step(encode(7'h00, 3'd3, OPC_BRANCH), 1'b0, 1'b1, 1'b0);
        step(encode(7'h00, 3'd3, OPC_LOAD), 1'b0, 1'b0, 1'b0);
        step(encode(7'h00, 3'd6, OPC_LOAD), 1'b0, 1'b0, 1'b0);
        step(encode(7'h00, 3'd7, OPC_LOAD), 1'b0, 1'b0, 1'b0);
        step(encode(7'h00, 3'd3, OPC_STORE), 1'b0, 1'b0, 1'b0);
        step(encode(7'h00, 3'd7, OPC_STORE), 1'b0, 1'b0, 1'b0);
        step(encode(7'h00, 3'd1, OPC_JALR), 1'b1, 1'b1, 1'b0);
        step(encode(7'h01, 3'd0, OPC_OP), 1'b0, 1'b0, 1'b0);
        step(encode(7'h20, 3'd1, OPC_OP), 1'b0, 1'b0, 1'b0);
        step(encode(7'h20, 3'd4, OPC_OP), 1'b0, 1'b0, 1'b0);
        step(encode(7'h20, 3'd1, OPC_OP_IMM), 1'b0, 1'b0, 1'b0);
        step(encode(7'h10, 3'd5, OPC_OP_IMM), 1'b0, 1'b0, 1'b0);
        repeat (10) begin
            random_unlisted(opc);
            take_bits(2, flags);
            step(encode(7'h2a, 3'd0, opc), flags[1], flags[0], 1'b0);
        end
        finish_test();

        start_test("random_stream");
        run_random(RANDOM_VECS, -1);
        finish_test();

        start_test("mid_reset");
        run_random(MIDRESET_VECS, 15);
        finish_test();

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== execute_ctl.f ====
+incdir+tb
design/execute_ctl_pkg.sv
design/instr_decoder.sv
design/branch_resolve_stage.sv
design/execute_ctl.sv
tb/tb_execute_ctl.sv

// ==== Bender.yml ====
package:
  name: execute_ctl

sources:
  - design/execute_ctl_pkg.sv
  - design/instr_decoder.sv
  - design/branch_resolve_stage.sv
  - design/execute_ctl.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_execute_ctl.sv
